/* rtl/pio_pkg.sv */
//**************************************************************************
// PIO register fabric package
// Bus widths, address map, register reset values and the master request
//**************************************************************************

package pio_pkg;

	localparam int PIO_NBITS = 32;
	localparam int PIO_ADDR_NBITS = 16;
	localparam int BLK_ID_NBITS = 8;
	localparam int REG_OFF_NBITS = 8;

	localparam int SUB_EXP_TIME_NBITS = 16;
	localparam int SCI_NBITS = 10;
	localparam int CLASS2PRI_NBITS = 16;
	localparam int LINK_ENABLE_NBITS = 4;
	localparam int CREDIT_LIMIT_NBITS = 8;

	typedef logic [PIO_NBITS-1:0] pio_data_t;
	typedef logic [PIO_ADDR_NBITS-1:0] pio_addr_t;
	typedef logic [BLK_ID_NBITS-1:0] blk_id_t;
	typedef logic [REG_OFF_NBITS-1:0] reg_off_t;

	typedef logic [SUB_EXP_TIME_NBITS-1:0] sub_exp_time_t;
	typedef logic [SCI_NBITS-1:0] sci_t;
	typedef logic [CLASS2PRI_NBITS-1:0] class2pri_t;
	typedef logic [LINK_ENABLE_NBITS-1:0] link_enable_t;
	typedef logic [CREDIT_LIMIT_NBITS-1:0] credit_limit_t;

	typedef enum logic {
		op_read,
		op_write
	} pio_op_t;

	// Held stable by a master while its req is high
	typedef struct packed {
		pio_op_t   op;
		pio_addr_t addr;
		pio_data_t wdata;
	} pio_req_t;

	// Block ids in the upper address byte
	localparam blk_id_t BLK_ASA = 8'h01;
	localparam blk_id_t BLK_LINK = 8'h02;

	localparam reg_off_t ASA_DEFAULT_SUB_EXP_TIME = 8'h00;
	localparam reg_off_t ASA_SUPERVISOR_SCI = 8'h04;
	localparam reg_off_t ASA_CLASS2PRI = 8'h08;
	localparam reg_off_t LINK_ENABLE = 8'h00;
	localparam reg_off_t LINK_CREDIT_LIMIT = 8'h04;
	localparam reg_off_t LINK_SCRATCH = 8'h08;

	localparam sub_exp_time_t SUB_EXP_TIME_RESET = 16'd3;
	localparam sci_t SUPERVISOR_SCI_RESET = '0;
	localparam class2pri_t CLASS2PRI_RESET = '0;
	localparam link_enable_t LINK_ENABLE_RESET = 4'hF;
	localparam credit_limit_t CREDIT_LIMIT_RESET = 8'd32;
	localparam pio_data_t SCRATCH_RESET = '0;

	function automatic blk_id_t addr_blk(input pio_addr_t addr);
		return addr[PIO_ADDR_NBITS-1 -: BLK_ID_NBITS];
	endfunction

	function automatic reg_off_t addr_off(input pio_addr_t addr);
		return addr[REG_OFF_NBITS-1:0];
	endfunction

endpackage

/* rtl/pio_arbiter.sv */
//**************************************************************************
// PIO bus arbiter
// Round-robin grant between host and mgmt four-phase ports, driving
// one strobe at a time onto the shared register bus
//**************************************************************************

module pio_arbiter import pio_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      host_req,
	input  pio_req_t  host_cmd,
	output logic      host_ack,
	output pio_data_t host_rdata,
	input  logic      mgmt_req,
	input  pio_req_t  mgmt_cmd,
	output logic      mgmt_ack,
	output pio_data_t mgmt_rdata,
	output logic      reg_rd,
	output logic      reg_wr,
	output pio_addr_t reg_addr,
	output pio_data_t reg_din,
	input  logic      bus_ack,
	input  logic      bus_rvalid,
	input  pio_data_t bus_rdata
);

	typedef enum logic [1:0] {
		arb_idle,
		arb_strobe,
		arb_wait_done,
		arb_ack_hold
	} arb_state_t;

	arb_state_t state;
	pio_req_t cmd_q;
	logic last_mgmt;
	logic pick_mgmt;
	logic gnt_req;

	// Mgmt wins when alone, or when host had the last grant
	assign pick_mgmt = mgmt_req & (~host_req | ~last_mgmt);
	assign gnt_req = last_mgmt ? mgmt_req : host_req;

	assign reg_rd = (state == arb_strobe) & (cmd_q.op == op_read);
	assign reg_wr = (state == arb_strobe) & (cmd_q.op == op_write);
	assign reg_addr = cmd_q.addr;
	assign reg_din = cmd_q.wdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= arb_idle;
			last_mgmt <= 1'b0;
			host_ack <= 1'b0;
			mgmt_ack <= 1'b0;
		end else begin
			case (state)
				arb_idle: begin
					if (host_req | mgmt_req) begin
						last_mgmt <= pick_mgmt;
						state <= arb_strobe;
					end
				end
				arb_strobe: state <= arb_wait_done;
				arb_wait_done: begin
					if (bus_ack | bus_rvalid) begin
						host_ack <= ~last_mgmt;
						mgmt_ack <= last_mgmt;
						state <= arb_ack_hold;
					end
				end
				default: begin
					// Ack follows req down
					if (!gnt_req) begin
						host_ack <= 1'b0;
						mgmt_ack <= 1'b0;
					end
					// Grant ends once ack is low or going low and the bus flags are clear
					if ((!gnt_req || !(host_ack || mgmt_ack)) && !bus_ack && !bus_rvalid)
						state <= arb_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == arb_idle)
			cmd_q <= pick_mgmt ? mgmt_cmd : host_cmd;
		if (state == arb_wait_done && bus_rvalid) begin
			if (last_mgmt)
				mgmt_rdata <= bus_rdata;
			else
				host_rdata <= bus_rdata;
		end
	end

endmodule

/* rtl/pio_decode.sv */
//**************************************************************************
// PIO address decoder
// Block selects, response mux and completion of unmapped block ids
//**************************************************************************

module pio_decode import pio_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      reg_rd,
	input  logic      reg_wr,
	input  pio_addr_t reg_addr,
	output logic      bus_ack,
	output logic      bus_rvalid,
	output pio_data_t bus_rdata,
	output logic      asa_bs,
	output logic      link_bs,
	input  logic      asa_ack,
	input  logic      asa_rvalid,
	input  pio_data_t asa_rdata,
	input  logic      link_ack,
	input  logic      link_rvalid,
	input  pio_data_t link_rdata
);

	typedef enum logic [1:0] {
		dec_idle,
		dec_busy,
		dec_unmapped
	} decode_state_t;

	decode_state_t state;
	logic wr_q;
	logic strobe;
	logic hit_asa;
	logic hit_link;
	logic blk_done;

	assign strobe = reg_rd | reg_wr;
	assign hit_asa = addr_blk(reg_addr) == BLK_ASA;
	assign hit_link = addr_blk(reg_addr) == BLK_LINK;

	// Select held from the strobe until the block completes
	assign asa_bs = hit_asa & (strobe | (state == dec_busy));
	assign link_bs = hit_link & (strobe | (state == dec_busy));

	assign blk_done = (hit_asa & (asa_ack | asa_rvalid)) | (hit_link & (link_ack | link_rvalid));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dec_idle;
			wr_q <= 1'b0;
		end else begin
			case (state)
				dec_idle: begin
					if (strobe) begin
						wr_q <= reg_wr;
						state <= (hit_asa | hit_link) ? dec_busy : dec_unmapped;
					end
				end
				dec_busy: if (blk_done) state <= dec_idle;
				default: state <= dec_idle;
			endcase
		end
	end

	always_comb begin
		bus_ack = (hit_asa & asa_ack) | (hit_link & link_ack);
		bus_rvalid = (hit_asa & asa_rvalid) | (hit_link & link_rvalid);
		bus_rdata = '0;
		if (hit_asa)
			bus_rdata = asa_rdata;
		else if (hit_link)
			bus_rdata = link_rdata;
		// Unmapped id completes in one cycle with zero data
		if (state == dec_unmapped) begin
			bus_ack = wr_q;
			bus_rvalid = ~wr_q;
		end
	end

endmodule

/* rtl/asa_reg.sv */
//**************************************************************************
// ASA register block
// Scheduler defaults: sub-expiry time, supervisor SCI, class priority map
//**************************************************************************

module asa_reg import pio_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          clk_div,
	input  logic          reg_bs,
	input  logic          reg_rd,
	input  logic          reg_wr,
	input  pio_addr_t     reg_addr,
	input  pio_data_t     reg_din,
	output logic          pio_ack,
	output logic          pio_rvalid,
	output pio_data_t     pio_rdata,
	output sub_exp_time_t default_sub_exp_time,
	output sci_t          supervisor_sci,
	output class2pri_t    class2pri
);

	logic acc_pend;
	logic rd_pend;
	logic rd_en;
	logic wr_sel;
	logic sel_sub_exp_time;
	logic sel_sci;
	logic sel_class2pri;

	assign wr_sel = reg_wr & reg_bs;
	assign rd_en = (reg_rd & reg_bs) | rd_pend;

	// Offset decode and read data for the held address
	always_comb begin
		sel_sub_exp_time = 1'b0;
		sel_sci = 1'b0;
		sel_class2pri = 1'b0;
		pio_rdata = '0;
		case (addr_off(reg_addr))
			ASA_DEFAULT_SUB_EXP_TIME: begin
				sel_sub_exp_time = 1'b1;
				pio_rdata = pio_data_t'(default_sub_exp_time);
			end
			ASA_SUPERVISOR_SCI: begin
				sel_sci = 1'b1;
				pio_rdata = pio_data_t'(supervisor_sci);
			end
			ASA_CLASS2PRI: begin
				sel_class2pri = 1'b1;
				pio_rdata = pio_data_t'(class2pri);
			end
			default: pio_rdata = '0;
		endcase
	end

	// Completion pacing on clk_div
	always_ff @(posedge clk) begin
		if (reset) begin
			acc_pend <= 1'b0;
			rd_pend <= 1'b0;
			pio_ack <= 1'b0;
			pio_rvalid <= 1'b0;
		end else begin
			if ((reg_rd | reg_wr) & reg_bs)
				acc_pend <= 1'b1;
			else if (clk_div)
				acc_pend <= 1'b0;

			if (reg_rd & reg_bs)
				rd_pend <= 1'b1;
			else if (pio_rvalid)
				rd_pend <= 1'b0;

			// Flags hold until the next clk_div
			if (clk_div) begin
				pio_ack <= acc_pend & ~rd_en;
				pio_rvalid <= acc_pend & rd_en & reg_bs;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			default_sub_exp_time <= SUB_EXP_TIME_RESET;
			supervisor_sci <= SUPERVISOR_SCI_RESET;
			class2pri <= CLASS2PRI_RESET;
		end else begin
			if (wr_sel & sel_sub_exp_time)
				default_sub_exp_time <= reg_din[SUB_EXP_TIME_NBITS-1:0];
			if (wr_sel & sel_sci)
				supervisor_sci <= reg_din[SCI_NBITS-1:0];
			if (wr_sel & sel_class2pri)
				class2pri <= reg_din[CLASS2PRI_NBITS-1:0];
		end
	end

endmodule

/* rtl/link_reg.sv */
//**************************************************************************
// Link register block
// Link enables, credit limit and a scratch word on the PIO bus
//**************************************************************************

module link_reg import pio_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          clk_div,
	input  logic          reg_bs,
	input  logic          reg_rd,
	input  logic          reg_wr,
	input  pio_addr_t     reg_addr,
	input  pio_data_t     reg_din,
	output logic          pio_ack,
	output logic          pio_rvalid,
	output pio_data_t     pio_rdata,
	output link_enable_t  link_enable,
	output credit_limit_t credit_limit,
	output pio_data_t     scratch
);

	logic acc_pend;
	logic rd_pend;
	logic rd_en;
	logic wr_sel;
	logic sel_enable;
	logic sel_credit;
	logic sel_scratch;

	assign wr_sel = reg_wr & reg_bs;
	assign rd_en = (reg_rd & reg_bs) | rd_pend;

	assign sel_enable = addr_off(reg_addr) == LINK_ENABLE;
	assign sel_credit = addr_off(reg_addr) == LINK_CREDIT_LIMIT;
	assign sel_scratch = addr_off(reg_addr) == LINK_SCRATCH;

	// Unmapped offsets read back zero
	assign pio_rdata = sel_enable ? pio_data_t'(link_enable) :
		sel_credit ? pio_data_t'(credit_limit) :
		sel_scratch ? scratch : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc_pend <= 1'b0;
			rd_pend <= 1'b0;
			pio_ack <= 1'b0;
			pio_rvalid <= 1'b0;
		end else begin
			if ((reg_rd | reg_wr) & reg_bs)
				acc_pend <= 1'b1;
			else if (clk_div)
				acc_pend <= 1'b0;
			if (reg_rd & reg_bs)
				rd_pend <= 1'b1;
			else if (pio_rvalid)
				rd_pend <= 1'b0;
			if (clk_div) begin
				pio_ack <= acc_pend & ~rd_en;
				pio_rvalid <= acc_pend & rd_en & reg_bs;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			link_enable <= LINK_ENABLE_RESET;
			credit_limit <= CREDIT_LIMIT_RESET;
			scratch <= SCRATCH_RESET;
		end else begin
			if (wr_sel & sel_enable)
				link_enable <= reg_din[LINK_ENABLE_NBITS-1:0];
			if (wr_sel & sel_credit)
				credit_limit <= reg_din[CREDIT_LIMIT_NBITS-1:0];
			if (wr_sel & sel_scratch)
				scratch <= reg_din;
		end
	end

endmodule

/* rtl/pio_subsys_top.sv */
//**************************************************************************
// PIO subsystem top
// Arbiter, decoder and the two register blocks of the scheduler config
//**************************************************************************

module pio_subsys_top import pio_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          clk_div,
	input  logic          host_req,
	input  pio_req_t      host_cmd,
	output logic          host_ack,
	output pio_data_t     host_rdata,
	input  logic          mgmt_req,
	input  pio_req_t      mgmt_cmd,
	output logic          mgmt_ack,
	output pio_data_t     mgmt_rdata,
	output sub_exp_time_t default_sub_exp_time,
	output sci_t          supervisor_sci,
	output class2pri_t    class2pri,
	output link_enable_t  link_enable,
	output credit_limit_t credit_limit,
	output pio_data_t     scratch
);

	logic reg_rd;
	logic reg_wr;
	pio_addr_t reg_addr;
	pio_data_t reg_din;
	logic bus_ack;
	logic bus_rvalid;
	pio_data_t bus_rdata;
	logic asa_bs;
	logic asa_ack;
	logic asa_rvalid;
	pio_data_t asa_rdata;
	logic link_bs;
	logic link_ack;
	logic link_rvalid;
	pio_data_t link_rdata;

	pio_arbiter i_pio_arbiter (
		.clk        (clk),
		.reset      (reset),
		.host_req   (host_req),
		.host_cmd   (host_cmd),
		.host_ack   (host_ack),
		.host_rdata (host_rdata),
		.mgmt_req   (mgmt_req),
		.mgmt_cmd   (mgmt_cmd),
		.mgmt_ack   (mgmt_ack),
		.mgmt_rdata (mgmt_rdata),
		.reg_rd     (reg_rd),
		.reg_wr     (reg_wr),
		.reg_addr   (reg_addr),
		.reg_din    (reg_din),
		.bus_ack    (bus_ack),
		.bus_rvalid (bus_rvalid),
		.bus_rdata  (bus_rdata)
	);

	pio_decode i_pio_decode (
		.clk         (clk),
		.reset       (reset),
		.reg_rd      (reg_rd),
		.reg_wr      (reg_wr),
		.reg_addr    (reg_addr),
		.bus_ack     (bus_ack),
		.bus_rvalid  (bus_rvalid),
		.bus_rdata   (bus_rdata),
		.asa_bs      (asa_bs),
		.link_bs     (link_bs),
		.asa_ack     (asa_ack),
		.asa_rvalid  (asa_rvalid),
		.asa_rdata   (asa_rdata),
		.link_ack    (link_ack),
		.link_rvalid (link_rvalid),
		.link_rdata  (link_rdata)
	);

	asa_reg i_asa_reg (
		.clk                  (clk),
		.reset                (reset),
		.clk_div              (clk_div),
		.reg_bs               (asa_bs),
		.reg_rd               (reg_rd),
		.reg_wr               (reg_wr),
		.reg_addr             (reg_addr),
		.reg_din              (reg_din),
		.pio_ack              (asa_ack),
		.pio_rvalid           (asa_rvalid),
		.pio_rdata            (asa_rdata),
		.default_sub_exp_time (default_sub_exp_time),
		.supervisor_sci       (supervisor_sci),
		.class2pri            (class2pri)
	);

	link_reg i_link_reg (
		.clk          (clk),
		.reset        (reset),
		.clk_div      (clk_div),
		.reg_bs       (link_bs),
		.reg_rd       (reg_rd),
		.reg_wr       (reg_wr),
		.reg_addr     (reg_addr),
		.reg_din      (reg_din),
		.pio_ack      (link_ack),
		.pio_rvalid   (link_rvalid),
		.pio_rdata    (link_rdata),
		.link_enable  (link_enable),
		.credit_limit (credit_limit),
		.scratch      (scratch)
	);

endmodule

/* verification/tb_pio_subsys.sv */
//**************************************************************************
// PIO subsystem testbench
// Replays the stimulus file on the host and mgmt ports and checks read
// data, the four-phase handshakes and the configuration outputs
//**************************************************************************

module tb_pio_subsys import pio_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int LINE_CYCLES = 40;
	localparam int ACK_LIMIT = 100;
	localparam int HOLD_CYCLES = 12;
	localparam int MAX_LINES = 64;

	logic clk;
	logic reset;
	logic clk_div;
	logic host_req;
	pio_req_t host_cmd;
	logic host_ack;
	pio_data_t host_rdata;
	logic mgmt_req;
	pio_req_t mgmt_cmd;
	logic mgmt_ack;
	pio_data_t mgmt_rdata;
	sub_exp_time_t default_sub_exp_time;
	sci_t supervisor_sci;
	class2pri_t class2pri;
	link_enable_t link_enable;
	credit_limit_t credit_limit;
	pio_data_t scratch;

	// One entry per stimulus line
	pio_req_t line_cmd [MAX_LINES];
	pio_data_t line_data [MAX_LINES];
	logic line_port [MAX_LINES];
	logic [1:0] line_flag [MAX_LINES];
	int line_no [MAX_LINES];
	int n_lines = 0;

	// Reference model of the register contents
	sub_exp_time_t exp_sub_exp_time;
	sci_t exp_sci;
	class2pri_t exp_class2pri;
	link_enable_t exp_link_enable;
	credit_limit_t exp_credit_limit;
	pio_data_t exp_scratch;

	int value_errors = 0;
	int fault_errors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	logic [31:0] rng_state = 32'h7bda_9d28;
	int since_div;
	logic prev_host_req;
	logic prev_mgmt_req;
	int i;

	pio_subsys_top i_pio_subsys_top (
		.clk                  (clk),
		.reset                (reset),
		.clk_div              (clk_div),
		.host_req             (host_req),
		.host_cmd             (host_cmd),
		.host_ack             (host_ack),
		.host_rdata           (host_rdata),
		.mgmt_req             (mgmt_req),
		.mgmt_cmd             (mgmt_cmd),
		.mgmt_ack             (mgmt_ack),
		.mgmt_rdata           (mgmt_rdata),
		.default_sub_exp_time (default_sub_exp_time),
		.supervisor_sci       (supervisor_sci),
		.class2pri            (class2pri),
		.link_enable          (link_enable),
		.credit_limit         (credit_limit),
		.scratch              (scratch)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input pio_data_t expected,
			input pio_data_t actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_outputs(input string tag);
		check_value({tag, " default_sub_exp_time"}, pio_data_t'(exp_sub_exp_time),
			pio_data_t'(default_sub_exp_time));
		check_value({tag, " supervisor_sci"}, pio_data_t'(exp_sci), pio_data_t'(supervisor_sci));
		check_value({tag, " class2pri"}, pio_data_t'(exp_class2pri), pio_data_t'(class2pri));
		check_value({tag, " link_enable"}, pio_data_t'(exp_link_enable),
			pio_data_t'(link_enable));
		check_value({tag, " credit_limit"}, pio_data_t'(exp_credit_limit),
			pio_data_t'(credit_limit));
		check_value({tag, " scratch"}, exp_scratch, scratch);
	endtask

	// Each register keeps only its own low bits
	// Unmapped addresses change nothing
	task automatic model_write(input pio_addr_t addr, input pio_data_t wdata);
		if (addr[15:8] == BLK_ASA) begin
			case (addr[7:0])
				ASA_DEFAULT_SUB_EXP_TIME: exp_sub_exp_time = wdata[SUB_EXP_TIME_NBITS-1:0];
				ASA_SUPERVISOR_SCI: exp_sci = wdata[SCI_NBITS-1:0];
				ASA_CLASS2PRI: exp_class2pri = wdata[CLASS2PRI_NBITS-1:0];
				default: ;
			endcase
		end else if (addr[15:8] == BLK_LINK) begin
			case (addr[7:0])
				LINK_ENABLE: exp_link_enable = wdata[LINK_ENABLE_NBITS-1:0];
				LINK_CREDIT_LIMIT: exp_credit_limit = wdata[CREDIT_LIMIT_NBITS-1:0];
				LINK_SCRATCH: exp_scratch = wdata;
				default: ;
			endcase
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int code;
		int src_line;
		string text;
		logic [31:0] port_v;
		logic [31:0] op_v;
		logic [31:0] addr_v;
		logic [31:0] data_v;
		logic [31:0] flag_v;
		fd = $fopen("verification/pio_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file verification/pio_stimulus.txt");
			fault_errors++;
		end else begin
			src_line = 0;
			while (!$feof(fd)) begin
				code = $fgets(text, fd);
				src_line++;
				if (code > 0 && text.len() > 1 && text[0] != "#") begin
					code = $sscanf(text, "%h %h %h %h %h", port_v, op_v, addr_v, data_v, flag_v);
					if (code != 5 || n_lines >= MAX_LINES) begin
						$display("Stimulus line %0d is malformed or does not fit the table", src_line);
						fault_errors++;
					end else begin
						line_port[n_lines] = port_v[0];
						line_cmd[n_lines].op = op_v[0] ? op_write : op_read;
						line_cmd[n_lines].addr = addr_v[15:0];
						line_cmd[n_lines].wdata = op_v[0] ? data_v : '0;
						line_data[n_lines] = data_v;
						line_flag[n_lines] = flag_v[1:0];
						line_no[n_lines] = src_line;
						n_lines++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_req(input logic port, input logic req, input pio_req_t cmd);
		if (port) begin
			mgmt_cmd <= cmd;
			mgmt_req <= req;
		end else begin
			host_cmd <= cmd;
			host_req <= req;
		end
	endtask

	// Full four-phase transfer for one stimulus line
	task automatic run_access(input int idx, input logic hold_long);
		int waited;
		logic ack;
		pio_data_t rdata;
		string name;
		name = $sformatf("line %0d %s %s %h", line_no[idx], line_port[idx] ? "mgmt" : "host",
			line_cmd[idx].op == op_write ? "write" : "read", line_cmd[idx].addr);
		ack = 1'b0;
		rdata = '0;
		waited = 0;
		@(posedge clk);
		drive_req(line_port[idx], 1'b1, line_cmd[idx]);
		while (!ack && waited < ACK_LIMIT) begin
			@(posedge clk);
			ack = line_port[idx] ? mgmt_ack : host_ack;
			rdata = line_port[idx] ? mgmt_rdata : host_rdata;
			waited++;
		end
		if (!ack) begin
			$display("Handshake stalled: %s never received ack", name);
			fault_errors++;
		end else if (line_cmd[idx].op == op_write)
			model_write(line_cmd[idx].addr, line_cmd[idx].wdata);
		else
			check_value(name, line_data[idx], rdata);
		// Slow master keeps req up and blocks the other port meanwhile
		if (hold_long)
			repeat (HOLD_CYCLES) @(posedge clk);
		drive_req(line_port[idx], 1'b0, line_cmd[idx]);
		waited = 0;
		while (ack && waited < ACK_LIMIT) begin
			@(posedge clk);
			ack = line_port[idx] ? mgmt_ack : host_ack;
			waited++;
		end
		if (ack) begin
			$display("Handshake stalled: %s ack stayed high after req dropped", name);
			fault_errors++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Slow enable that is high at least once every 6 cycles
	initial begin
		clk_div <= 1'b0;
		since_div = 0;
		forever begin
			@(posedge clk);
			rng_state = xorshift32(rng_state);
			if (rng_state[1:0] == 2'b00 || since_div >= 5) begin
				clk_div <= 1'b1;
				since_div = 0;
			end else begin
				clk_div <= 1'b0;
				since_div++;
			end
		end
	end

	// Ack may outlast req by one cycle only
	initial begin
		prev_host_req = 1'b0;
		prev_mgmt_req = 1'b0;
		forever begin
			@(posedge clk);
			if (!reset && host_ack && !host_req && !prev_host_req) begin
				$display("Protocol violation: host ack is high while host req stays low");
				fault_errors++;
			end
			if (!reset && mgmt_ack && !mgmt_req && !prev_mgmt_req) begin
				$display("Protocol violation: mgmt ack is high while mgmt req stays low");
				fault_errors++;
			end
			prev_host_req = host_req;
			prev_mgmt_req = mgmt_req;
		end
	end

	initial begin
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Summary: %0d value errors, %0d other errors", value_errors, fault_errors);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		reset <= 1'b1;
		host_req <= 1'b0;
		host_cmd <= '0;
		mgmt_req <= 1'b0;
		mgmt_cmd <= '0;
		exp_sub_exp_time = SUB_EXP_TIME_RESET;
		exp_sci = SUPERVISOR_SCI_RESET;
		exp_class2pri = CLASS2PRI_RESET;
		exp_link_enable = LINK_ENABLE_RESET;
		exp_credit_limit = CREDIT_LIMIT_RESET;
		exp_scratch = SCRATCH_RESET;
		load_stimulus();
		cycle_limit = RESET_CYCLES + LINE_CYCLES * (n_lines + 1);
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_outputs("reset");
		i = 0;
		while (i < n_lines) begin
			// Flagged line starts in the same cycle as the next one
			if (line_flag[i] != 2'd0 && i + 1 < n_lines) begin
				fork
					run_access(i, line_flag[i] == 2'd2);
					run_access(i + 1, 1'b0);
				join
				check_outputs($sformatf("after line %0d", line_no[i + 1]));
				i = i + 2;
			end else begin
				run_access(i, 1'b0);
				check_outputs($sformatf("after line %0d", line_no[i]));
				i = i + 1;
			end
		end
		$display("Summary: %0d value errors, %0d other errors", value_errors, fault_errors);
		if (value_errors == 0 && fault_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* verification/pio_stimulus.txt */
# port (0 host, 1 mgmt)  op (0 read, 1 write)  addr  data (write data or expected read)
# flag: 0 alone, 1 starts with the next line, 2 as 1 and this port holds req long
0 0 0100 00000003 0
0 0 0104 00000000 0
0 0 0108 00000000 0
0 0 0200 0000000f 0
0 0 0204 00000020 0
0 0 0208 00000000 0
0 1 0100 abcd1234 0
1 0 0100 00001234 0
1 1 0104 fffffe55 0
0 0 0104 00000255 0
1 1 0200 0000003a 0
0 0 0200 0000000a 0
0 1 010c 12345678 0
1 0 010c 00000000 0
1 1 0210 ffffffff 0
0 0 0210 00000000 0
0 1 0300 deadbeef 0
1 0 0300 00000000 0
0 1 0108 0001beef 1
1 1 0204 00000177 0
0 0 0108 0000beef 1
1 0 0204 00000077 0
0 1 0208 cafef00d 2
1 1 0100 00005a5a 0
1 0 0208 cafef00d 1
0 0 0100 00005a5a 0

/* sim.f */
rtl/pio_pkg.sv
rtl/pio_arbiter.sv
rtl/pio_decode.sv
rtl/asa_reg.sv
rtl/link_reg.sv
rtl/pio_subsys_top.sv
verification/tb_pio_subsys.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_pio_subsys
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
